/* source/sram_consts.svh */
`ifndef SRAM_CONSTS_SVH
`define SRAM_CONSTS_SVH

// word address into the 256K x 16 part
`define SRAM_ADDR_BITS 18

// sram data bus width
`define SRAM_DATA_BITS 16

// requester tag on the cpu memory bus
// zero means no request
`define BUS_TAG_BITS 4

// words fetched per vga scanline
`define LINE_WORDS 64

`endif

/* source/sram_pkg.sv */
package sram_pkg;

	// operation the controller starts on a rising edge
	typedef enum logic [1:0] {
		OP_NONE   = 2'd0,
		OP_BUS_RD = 2'd1,
		OP_BUS_WR = 2'd2,
		OP_VGA_RD = 2'd3
	} bus_op_e;

	// scanline fetcher states
	typedef enum logic [1:0] {
		FS_IDLE  = 2'd0,
		FS_ISSUE = 2'd1, // vga_req held high
		FS_DRAIN = 2'd2  // last words still returning
	} fetch_state_e;

endpackage

/* source/mem_bus_if.sv */
`timescale 1ns/1ps
`include "sram_consts.svh"

interface mem_bus_if;

	logic [`BUS_TAG_BITS-1:0]   request; // nonzero tag starts a cycle
	logic                       we;
	logic                       ub;      // upper byte enable
	logic                       lb;      // lower byte enable
	logic [`SRAM_ADDR_BITS-1:0] addr;
	logic [`SRAM_DATA_BITS-1:0] wdata;

	logic [`SRAM_DATA_BITS-1:0] rdata;
	logic [`BUS_TAG_BITS-1:0]   ack;     // echo of the served tag
	logic                       stall;

	// cpu side
	modport host (
		output request, we, ub, lb, addr, wdata,
		input  rdata, ack, stall
	);

	// controller side
	modport mem (
		input  request, we, ub, lb, addr, wdata,
		output rdata, ack, stall
	);

endinterface

/* source/sram_ctrl.sv */
`timescale 1ns/1ps
`include "sram_consts.svh"

module sram_ctrl (
	input  logic                       I_clk,
	input  logic                       rst,
	mem_bus_if.mem                     bus,
	input  logic                       vga_req,
	input  logic [`SRAM_ADDR_BITS-1:0] vga_addr,
	output logic [`SRAM_DATA_BITS-1:0] vga_data,
	output logic [`SRAM_ADDR_BITS-1:0] sram_addr,
	output logic [`SRAM_DATA_BITS-1:0] sram_dq_out,
	output logic                       sram_dq_oe,
	input  logic [`SRAM_DATA_BITS-1:0] sram_dq_in,
	output logic                       sram_ce_n,
	output logic                       sram_oe_n,
	output logic                       sram_we_n,
	output logic                       sram_ub_n,
	output logic                       sram_lb_n
);
	import sram_pkg::*;

	bus_op_e op;

	// toggle pairs, first half set on posedge, second follows on negedge
	logic rd_tgl;
	logic rd_follow;
	logic wr_tgl;
	logic wr_follow;
	logic rd_pulse;
	logic wr_pulse;

	logic [`SRAM_DATA_BITS-1:0] rd_data;
	logic [`BUS_TAG_BITS-1:0]   ack_q;
	logic                       stall_q;

	// vga has priority over the cpu bus
	always_comb begin
		if (vga_req) begin
			op = OP_VGA_RD;
		end else if (bus.request != '0) begin
			op = bus.we ? OP_BUS_WR : OP_BUS_RD;
		end else begin
			op = OP_NONE;
		end
	end

	// strobe is active while the pair differs, i.e. first half cycle
	assign rd_pulse = rd_tgl ^ rd_follow;
	assign wr_pulse = wr_tgl ^ wr_follow;

	assign sram_oe_n = ~rd_pulse;
	assign sram_we_n = ~wr_pulse;
	assign sram_ce_n = 1'b0; // chip always selected

	// control side
	always_ff @(posedge I_clk) begin
		if (rst) begin
			rd_tgl     <= 1'b0;
			wr_tgl     <= 1'b0;
			sram_dq_oe <= 1'b0;
			ack_q      <= '0;
			stall_q    <= 1'b0;
		end else begin
			case (op)
				OP_VGA_RD, OP_BUS_RD: begin
					rd_tgl <= ~rd_follow; // start read pulse
				end
				OP_BUS_WR: begin
					wr_tgl <= ~wr_follow; // start write pulse
				end
				default: begin
				end
			endcase
			sram_dq_oe <= (op == OP_BUS_WR);
			// only a served bus cycle gets its tag echoed
			ack_q   <= (op == OP_BUS_RD || op == OP_BUS_WR) ? bus.request : '0;
			stall_q <= vga_req;
		end
	end

	// address, write data and byte lanes
	always_ff @(posedge I_clk) begin
		case (op)
			OP_VGA_RD: begin
				sram_addr <= vga_addr;
				sram_ub_n <= 1'b0; // whole word for vga
				sram_lb_n <= 1'b0;
			end
			OP_BUS_RD: begin
				sram_addr <= bus.addr;
				sram_ub_n <= ~bus.ub;
				sram_lb_n <= ~bus.lb;
			end
			OP_BUS_WR: begin
				sram_addr   <= bus.addr;
				sram_dq_out <= bus.wdata;
				sram_ub_n   <= ~bus.ub;
				sram_lb_n   <= ~bus.lb;
			end
			default: begin
			end
		endcase
	end

	// second half of each pair ends the strobe
	always_ff @(negedge I_clk) begin
		if (rst) begin
			rd_follow <= 1'b0;
			wr_follow <= 1'b0;
		end else begin
			rd_follow <= rd_tgl;
			wr_follow <= wr_tgl;
		end
	end

	// sample the part while oe_n is still low
	always_ff @(negedge I_clk) begin
		if (rd_pulse) begin
			rd_data <= sram_dq_in;
		end
	end

	assign bus.rdata = rd_data;
	assign bus.ack   = ack_q;
	assign bus.stall = stall_q;

	// vga wants the bytes the other way round
	assign vga_data = {rd_data[7:0], rd_data[15:8]};

endmodule

/* source/vga_line_fetch.sv */
`timescale 1ns/1ps
`include "sram_consts.svh"

module vga_line_fetch (
	input  logic                           I_clk,
	input  logic                           rst,
	input  logic                           line_start,
	input  logic [`SRAM_ADDR_BITS-1:0]     line_base,
	output logic                           vga_req,
	output logic [`SRAM_ADDR_BITS-1:0]     vga_addr,
	input  logic [`SRAM_DATA_BITS-1:0]     vga_data,
	input  logic [$clog2(`LINE_WORDS)-1:0] pix_idx,
	output logic [`SRAM_DATA_BITS-1:0]     pix_word,
	output logic                           line_ready
);
	import sram_pkg::*;

	localparam int IDX_BITS = $clog2(`LINE_WORDS);

	fetch_state_e state;

	logic [IDX_BITS-1:0] req_idx;  // index of the word on vga_req now
	logic                fill_vld; // a word returns on the next edge
	logic [IDX_BITS-1:0] fill_idx;

	logic [`SRAM_DATA_BITS-1:0] line_buf [`LINE_WORDS];

	always_ff @(posedge I_clk) begin
		if (rst) begin
			state      <= FS_IDLE;
			vga_req    <= 1'b0;
			line_ready <= 1'b0;
			req_idx    <= '0;
		end else begin
			case (state)
				FS_IDLE: begin
					// start of a new line, old one no longer valid
					if (line_start) begin
						state      <= FS_ISSUE;
						line_ready <= 1'b0;
						vga_req    <= 1'b1;
						req_idx    <= '0;
					end
				end
				FS_ISSUE: begin
					if (req_idx == IDX_BITS'(`LINE_WORDS - 1)) begin
						vga_req <= 1'b0; // last word already requested
						state   <= FS_DRAIN;
					end else begin
						req_idx <= req_idx + 1'b1;
					end
				end
				FS_DRAIN: begin
					// wait until the last word has landed
					if (!fill_vld) begin
						line_ready <= 1'b1;
						state      <= FS_IDLE;
					end
				end
				default: begin
					state   <= FS_IDLE;
					vga_req <= 1'b0;
				end
			endcase
		end
	end

	// word address follows the request index
	always_ff @(posedge I_clk) begin
		if (state == FS_IDLE && line_start) begin
			vga_addr <= line_base;
		end else if (state == FS_ISSUE && vga_req) begin
			vga_addr <= vga_addr + 1'b1;
		end
	end

	// one cycle of read latency in the controller
	always_ff @(posedge I_clk) begin
		if (rst) begin
			fill_vld <= 1'b0;
		end else begin
			fill_vld <= vga_req;
		end
	end

	always_ff @(posedge I_clk) begin
		fill_idx <= req_idx;
	end

	always_ff @(posedge I_clk) begin
		if (fill_vld) begin
			line_buf[fill_idx] <= vga_data;
		end
	end

	// pixel read port, registered
	always_ff @(posedge I_clk) begin
		pix_word <= line_buf[pix_idx];
	end

endmodule

/* source/sram_vga_top.sv */
`timescale 1ns/1ps
`include "sram_consts.svh"

module sram_vga_top (
	input  logic                           I_clk,
	input  logic                           rst,
	// cpu memory bus
	input  logic [`BUS_TAG_BITS-1:0]       request,
	input  logic                           we,
	input  logic                           ub,
	input  logic                           lb,
	input  logic [`SRAM_ADDR_BITS-1:0]     addr,
	input  logic [`SRAM_DATA_BITS-1:0]     wdata,
	output logic [`SRAM_DATA_BITS-1:0]     rdata,
	output logic [`BUS_TAG_BITS-1:0]       ack,
	output logic                           stall,
	// scanline side
	input  logic                           line_start,
	input  logic [`SRAM_ADDR_BITS-1:0]     line_base,
	input  logic [$clog2(`LINE_WORDS)-1:0] pix_idx,
	output logic [`SRAM_DATA_BITS-1:0]     pix_word,
	output logic                           line_ready,
	// sram pins, pad is built by the board wrapper
	output logic [`SRAM_ADDR_BITS-1:0]     sram_addr,
	output logic [`SRAM_DATA_BITS-1:0]     sram_dq_out,
	output logic                           sram_dq_oe,
	input  logic [`SRAM_DATA_BITS-1:0]     sram_dq_in,
	output logic                           sram_ce_n,
	output logic                           sram_oe_n,
	output logic                           sram_we_n,
	output logic                           sram_ub_n,
	output logic                           sram_lb_n
);

	logic                       vga_req;
	logic [`SRAM_ADDR_BITS-1:0] vga_addr;
	logic [`SRAM_DATA_BITS-1:0] vga_data;

	mem_bus_if i_bus ();

	// host side of the bus comes straight from the ports
	assign i_bus.request = request;
	assign i_bus.we      = we;
	assign i_bus.ub      = ub;
	assign i_bus.lb      = lb;
	assign i_bus.addr    = addr;
	assign i_bus.wdata   = wdata;
	assign rdata         = i_bus.rdata;
	assign ack           = i_bus.ack;
	assign stall         = i_bus.stall;

	vga_line_fetch i_vga_line_fetch (
		.I_clk      (I_clk),
		.rst        (rst),
		.line_start (line_start),
		.line_base  (line_base),
		.vga_req    (vga_req),
		.vga_addr   (vga_addr),
		.vga_data   (vga_data),
		.pix_idx    (pix_idx),
		.pix_word   (pix_word),
		.line_ready (line_ready)
	);

	sram_ctrl i_sram_ctrl (
		.I_clk       (I_clk),
		.rst         (rst),
		.bus         (i_bus.mem),
		.vga_req     (vga_req),
		.vga_addr    (vga_addr),
		.vga_data    (vga_data),
		.sram_addr   (sram_addr),
		.sram_dq_out (sram_dq_out),
		.sram_dq_oe  (sram_dq_oe),
		.sram_dq_in  (sram_dq_in),
		.sram_ce_n   (sram_ce_n),
		.sram_oe_n   (sram_oe_n),
		.sram_we_n   (sram_we_n),
		.sram_ub_n   (sram_ub_n),
		.sram_lb_n   (sram_lb_n)
	);

endmodule

/* tests/sram_model.sv */
`timescale 1ns/1ps
`include "sram_consts.svh"

// behavioral 256K x 16 asynchronous sram
// the board pad is split into a write side and a read side
module sram_model (
	input  logic [`SRAM_ADDR_BITS-1:0] addr,
	input  logic [`SRAM_DATA_BITS-1:0] dq_wr,    // controller drives the pad
	input  logic                       dq_wr_en,
	output logic [`SRAM_DATA_BITS-1:0] dq_rd,    // part drives the pad
	input  logic                       ce_n,
	input  logic                       oe_n,
	input  logic                       we_n,
	input  logic                       ub_n,
	input  logic                       lb_n
);

	logic [`SRAM_DATA_BITS-1:0] mem [1 << `SRAM_ADDR_BITS];

	// data is latched as we_n goes back high
	always @(posedge we_n) begin
		if (!ce_n && dq_wr_en) begin
			if (!ub_n) begin
				mem[addr][15:8] <= dq_wr[15:8];
			end
			if (!lb_n) begin
				mem[addr][7:0] <= dq_wr[7:0];
			end
		end
	end

	// whole word out while oe_n is low and no write is going on
	assign dq_rd = (!ce_n && !oe_n && we_n) ? mem[addr] : '0;

endmodule

/* tests/tb_sram_vga.sv */
`timescale 1ns/1ps
`include "sram_consts.svh"

module tb_sram_vga;

	localparam int IDX_BITS   = $clog2(`LINE_WORDS);
	localparam int MAX_CYCLES = 1200;                // tests need about 550 cycles
	localparam int ACK_WAIT   = 2 * `LINE_WORDS + 20; // longest stall is one line fetch

	logic                       I_clk = 1'b0;
	logic                       rst;
	logic [`BUS_TAG_BITS-1:0]   request;
	logic                       we;
	logic                       ub;
	logic                       lb;
	logic [`SRAM_ADDR_BITS-1:0] addr;
	logic [`SRAM_DATA_BITS-1:0] wdata;
	logic [`SRAM_DATA_BITS-1:0] rdata;
	logic [`BUS_TAG_BITS-1:0]   ack;
	logic                       stall;
	logic                       line_start;
	logic [`SRAM_ADDR_BITS-1:0] line_base;
	logic [IDX_BITS-1:0]        pix_idx;
	logic [`SRAM_DATA_BITS-1:0] pix_word;
	logic                       line_ready;
	logic [`SRAM_ADDR_BITS-1:0] sram_addr;
	logic [`SRAM_DATA_BITS-1:0] sram_dq_out;
	logic                       sram_dq_oe;
	logic [`SRAM_DATA_BITS-1:0] sram_dq_in;
	logic                       sram_ce_n;
	logic                       sram_oe_n;
	logic                       sram_we_n;
	logic                       sram_ub_n;
	logic                       sram_lb_n;

	logic [`SRAM_DATA_BITS-1:0] ref_mem [1 << `SRAM_ADDR_BITS]; // expected sram contents
	logic [`BUS_TAG_BITS-1:0]   tag_seq = '0;

	int cycles = 0;
	int test_errs = 0;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	always #4 I_clk = ~I_clk;

	always @(posedge I_clk) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run went past %0d cycles without finishing", MAX_CYCLES);
			$display(">>> FAIL");
			$finish;
		end
	end

	sram_vga_top i_sram_vga_top (
		.I_clk       (I_clk),
		.rst         (rst),
		.request     (request),
		.we          (we),
		.ub          (ub),
		.lb          (lb),
		.addr        (addr),
		.wdata       (wdata),
		.rdata       (rdata),
		.ack         (ack),
		.stall       (stall),
		.line_start  (line_start),
		.line_base   (line_base),
		.pix_idx     (pix_idx),
		.pix_word    (pix_word),
		.line_ready  (line_ready),
		.sram_addr   (sram_addr),
		.sram_dq_out (sram_dq_out),
		.sram_dq_oe  (sram_dq_oe),
		.sram_dq_in  (sram_dq_in),
		.sram_ce_n   (sram_ce_n),
		.sram_oe_n   (sram_oe_n),
		.sram_we_n   (sram_we_n),
		.sram_ub_n   (sram_ub_n),
		.sram_lb_n   (sram_lb_n)
	);

	sram_model i_sram_model (
		.addr     (sram_addr),
		.dq_wr    (sram_dq_out),
		.dq_wr_en (sram_dq_oe),
		.dq_rd    (sram_dq_in),
		.ce_n     (sram_ce_n),
		.oe_n     (sram_oe_n),
		.we_n     (sram_we_n),
		.ub_n     (sram_ub_n),
		.lb_n     (sram_lb_n)
	);

	task automatic note_mismatch(input string name, input logic [15:0] exp,
			input logic [15:0] act);
		$display("MISMATCH %s expected %0h got %0h", name, exp, act);
		test_errs++;
	endtask

	task automatic note_failure(input string msg);
		$display("error: %s", msg);
		test_errs++;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errs == 0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: failed with %0d errors", name, test_errs);
			tests_failed++;
			errors += test_errs;
		end
		test_errs = 0;
	endtask

	// vga side sees the high byte low
	function automatic logic [15:0] byte_swap(input logic [15:0] w);
		return {w[7:0], w[15:8]};
	endfunction

	task automatic new_tag(output logic [`BUS_TAG_BITS-1:0] t);
		tag_seq = (tag_seq == 4'd15) ? 4'd1 : tag_seq + 4'd1; // zero is never a tag
		t = tag_seq;
	endtask

	// holds one transfer until it is acked
	task automatic bus_cycle(input logic [`BUS_TAG_BITS-1:0] t, input logic w,
			input logic u, input logic l, input logic [`SRAM_ADDR_BITS-1:0] a,
			input logic [`SRAM_DATA_BITS-1:0] d, output logic [`SRAM_DATA_BITS-1:0] rd,
			output int stalls);
		logic [`BUS_TAG_BITS-1:0] seen;
		stalls = 0;
		@(negedge I_clk);
		request = t;
		we = w;
		ub = u;
		lb = l;
		addr = a;
		wdata = d;
		@(negedge I_clk);
		while (ack == '0 && stalls < ACK_WAIT) begin
			if (stall !== 1'b1) begin
				note_mismatch("stall", 16'd1, 16'(stall));
			end
			stalls++;
			@(negedge I_clk);
		end
		seen = ack;
		request = '0; // drop before the next rising edge
		we = 1'b0;
		if (seen == '0) begin
			note_failure("no ack while the request was held");
		end else if (seen !== t) begin
			note_mismatch("ack", 16'(t), 16'(seen));
		end
		if (seen != '0 && stall !== 1'b0) begin
			note_mismatch("stall", 16'd0, 16'(stall));
		end
		@(posedge I_clk);
		rd = rdata; // captured on the falling edge before
		if (w && u) begin
			ref_mem[a][15:8] = d[15:8];
		end
		if (w && l) begin
			ref_mem[a][7:0] = d[7:0];
		end
	endtask

	task automatic pulse_line_start(input logic [`SRAM_ADDR_BITS-1:0] base);
		@(negedge I_clk);
		line_start = 1'b1;
		line_base = base;
		@(negedge I_clk);
		line_start = 1'b0;
	endtask

	task automatic wait_line_ready();
		int waited;
		waited = 0;
		@(negedge I_clk);
		while (line_ready !== 1'b1 && waited < `LINE_WORDS + 10) begin
			@(negedge I_clk);
			waited++;
		end
		if (line_ready !== 1'b1) begin
			note_failure("line_ready never came up after line_start");
		end
	endtask

	task automatic check_reset_state();
		if (ack !== '0) note_mismatch("ack", 16'd0, 16'(ack));
		if (stall !== 1'b0) note_mismatch("stall", 16'd0, 16'(stall));
		if (line_ready !== 1'b0) note_mismatch("line_ready", 16'd0, 16'(line_ready));
		if (sram_we_n !== 1'b1) note_mismatch("sram_we_n", 16'd1, 16'(sram_we_n));
		if (sram_oe_n !== 1'b1) note_mismatch("sram_oe_n", 16'd1, 16'(sram_oe_n));
		if (sram_dq_oe !== 1'b0) note_mismatch("sram_dq_oe", 16'd0, 16'(sram_dq_oe));
		if (sram_ce_n !== 1'b0) note_mismatch("sram_ce_n", 16'd0, 16'(sram_ce_n));
		finish_test("reset");
	endtask

	task automatic word_write_read();
		logic [`SRAM_ADDR_BITS-1:0] addrs [8];
		logic [`SRAM_DATA_BITS-1:0] rd;
		logic [`BUS_TAG_BITS-1:0]   t;
		int st;
		for (int i = 0; i < 8; i++) begin
			addrs[i] = 18'($urandom);
			new_tag(t);
			bus_cycle(t, 1'b1, 1'b1, 1'b1, addrs[i], 16'($urandom), rd, st);
			if (st != 0) note_failure("write acked late with the fetcher idle");
		end
		for (int i = 0; i < 8; i++) begin
			new_tag(t);
			bus_cycle(t, 1'b0, 1'b1, 1'b1, addrs[i], '0, rd, st);
			if (st != 0) note_failure("read acked late with the fetcher idle");
			if (rd !== ref_mem[addrs[i]]) note_mismatch("rdata", ref_mem[addrs[i]], rd);
		end
		finish_test("word_rw");
	endtask

	task automatic byte_lane_writes();
		logic [`SRAM_ADDR_BITS-1:0] a;
		logic [`SRAM_DATA_BITS-1:0] rd;
		logic [`BUS_TAG_BITS-1:0]   t;
		int st;
		for (int i = 0; i < 4; i++) begin
			a = 18'($urandom);
			new_tag(t);
			bus_cycle(t, 1'b1, 1'b1, 1'b1, a, 16'($urandom), rd, st); // known word first
			new_tag(t);
			bus_cycle(t, 1'b1, 1'b1, 1'b0, a, 16'($urandom), rd, st); // upper only
			new_tag(t);
			bus_cycle(t, 1'b0, 1'b1, 1'b1, a, '0, rd, st);
			if (rd !== ref_mem[a]) note_mismatch("rdata", ref_mem[a], rd);
			new_tag(t);
			bus_cycle(t, 1'b1, 1'b0, 1'b1, a, 16'($urandom), rd, st); // lower only
			new_tag(t);
			bus_cycle(t, 1'b0, 1'b1, 1'b1, a, '0, rd, st);
			if (rd !== ref_mem[a]) note_mismatch("rdata", ref_mem[a], rd);
		end
		finish_test("byte_lanes");
	endtask

	task automatic line_fetch_readback();
		logic [`SRAM_ADDR_BITS-1:0] base;
		logic [`SRAM_DATA_BITS-1:0] rd;
		logic [`SRAM_DATA_BITS-1:0] exp;
		logic [`BUS_TAG_BITS-1:0]   t;
		int st;
		base = 18'($urandom % ((1 << `SRAM_ADDR_BITS) - `LINE_WORDS)); // no wrap
		for (int i = 0; i < `LINE_WORDS; i++) begin
			new_tag(t);
			bus_cycle(t, 1'b1, 1'b1, 1'b1, base + 18'(i), 16'($urandom), rd, st);
		end
		pulse_line_start(base);
		wait_line_ready();
		for (int i = 0; i < `LINE_WORDS; i++) begin
			@(negedge I_clk);
			pix_idx = IDX_BITS'(i);
			@(negedge I_clk);
			exp = byte_swap(ref_mem[base + 18'(i)]);
			if (pix_word !== exp) note_mismatch("pix_word", exp, pix_word);
		end
		finish_test("line_fetch");
	endtask

	task automatic stall_during_fetch();
		logic [`SRAM_ADDR_BITS-1:0] base;
		logic [`SRAM_ADDR_BITS-1:0] a;
		logic [`SRAM_DATA_BITS-1:0] rd;
		logic [`BUS_TAG_BITS-1:0]   t;
		int st;
		base = 18'($urandom);
		a = base + 18'h100; // outside the fetched line
		pulse_line_start(base);
		new_tag(t);
		bus_cycle(t, 1'b1, 1'b1, 1'b1, a, 16'($urandom), rd, st);
		if (st == 0) note_failure("write was served while the fetch was issuing");
		wait_line_ready();
		pulse_line_start(base);
		new_tag(t);
		bus_cycle(t, 1'b0, 1'b1, 1'b1, a, '0, rd, st);
		if (st == 0) note_failure("read was served while the fetch was issuing");
		if (rd !== ref_mem[a]) note_mismatch("rdata", ref_mem[a], rd);
		wait_line_ready();
		finish_test("stall");
	endtask

	initial begin
		void'($urandom(32'h80a4));
		rst = 1'b1;
		request = '0;
		we = 1'b0;
		ub = 1'b0;
		lb = 1'b0;
		addr = '0;
		wdata = '0;
		line_start = 1'b0;
		line_base = '0;
		pix_idx = '0;
		repeat (4) @(negedge I_clk);
		rst = 1'b0;

		check_reset_state();
		word_write_read();
		byte_lane_writes();
		line_fetch_readback();
		stall_during_fetch();

		$display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* verilog.f */
+incdir+source
source/sram_pkg.sv
source/mem_bus_if.sv
source/sram_ctrl.sv
source/vga_line_fetch.sv
source/sram_vga_top.sv
tests/sram_model.sv
tests/tb_sram_vga.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with verilator, run it, then look for the pass line in the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --timescale 1ns/1ps \
	--top-module tb_sram_vga -Mdir "$OBJ" -f verilog.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$OBJ/Vtb_sram_vga" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q '^>>> PASS$' "$LOG"; then
	exit 0
else
	echo "pass line not found in $LOG"
	exit 1
fi
